//--- verification/video_golden.txt
// columns: op (1 write, 2 read, 3 probe, 4 frame check) _ a _ b _ c
// write: a=reg b=data; read: a=reg b=expected (reg 0 uses intr_status_i); probe: a=line b=col c=index
0002_0002_0280_0000
0002_0003_01e0_0000
0002_0004_003c_0000
0002_0000_0000_0000
0001_0000_0005_0000
// 8 bpp, colorbase 30
0001_0005_3020_0000
0002_0005_3020_0000
0001_0006_1234_0000
0002_0006_1234_0000
0001_0007_0140_0000
0002_0007_0140_0000
0003_0000_0000_0034
0003_0000_0001_00cb
0003_0002_0005_0049
0004_0000_0000_0000
// 4 bpp, colorbase a5
0001_0005_a510_0000
0002_0005_a510_0000
0001_0006_0100_0000
0001_0007_00a0_0000
0003_0001_0007_00ae
0003_0000_0000_00a0
0004_0000_0000_0000
// 1 bpp with attribute byte, colorbase 70
0001_0005_7000_0000
0001_0006_0010_0000
0001_0007_0050_0000
0003_0000_0000_0071
0003_0000_0003_0070
0003_0003_000f_0071
0004_0000_0000_0000
// blanked, colorbase 60
0001_0005_6080_0000
0002_0005_6080_0000
0004_0000_0000_0000

//--- video_gen.f
rtl/vgen_pkg.sv
rtl/vgen_timing_if.sv
rtl/plane_cfg_if.sv
rtl/video_timing.sv
rtl/video_regs.sv
rtl/plane_fetch.sv
rtl/pixel_scanout.sv
rtl/video_gen.sv
verification/video_gen_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the video generator testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary -f video_gen.f --top-module video_gen_tb -o video_gen_sim \
    && ./obj_dir/video_gen_sim | grep -q "sim passed" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

//--- verification/video_gen_tb.sv
// video generator testbench
// plays register writes, reads and pixel probes from the golden file and
// checks sync timing, interrupts and every visible pixel of selected frames
module video_gen_tb;
    timeunit 1ns;
    timeprecision 1ps;

    logic                  clk;
    logic                  reset_i;
    logic                  vgen_reg_wr_i;
    logic [4:0]            vgen_reg_num_i;
    logic [15:0]           vgen_reg_data_i;
    logic [15:0]           vgen_reg_data_o;
    logic [3:0]            intr_status_i;
    logic [3:0]            intr_signal_o;
    logic                  vram_sel_o;
    logic [15:0]           vram_addr_o;
    logic [15:0]           vram_data_i;
    logic [7:0]            color_index_o;
    logic                  hsync_o;
    logic                  vsync_o;
    logic                  dv_de_o;

    logic [63:0] golden [0:63];         // op, arg a, arg b, arg c
    logic [47:0] probes [$];            // line, column, expected index
    int          seed;
    logic [7:0]  sh_cb;                 // expected register contents
    logic        sh_blank;
    logic [1:0]  sh_bpp;
    logic [15:0] sh_start;
    logic [15:0] sh_ll;
    logic        pend_sel;
    logic [15:0] pend_addr;

    video_gen UUT (
        .clk(clk), .reset_i(reset_i),
        .vgen_reg_wr_i(vgen_reg_wr_i), .vgen_reg_num_i(vgen_reg_num_i),
        .vgen_reg_data_i(vgen_reg_data_i), .vgen_reg_data_o(vgen_reg_data_o),
        .intr_status_i(intr_status_i), .intr_signal_o(intr_signal_o),
        .vram_sel_o(vram_sel_o), .vram_addr_o(vram_addr_o), .vram_data_i(vram_data_i),
        .color_index_o(color_index_o), .hsync_o(hsync_o), .vsync_o(vsync_o),
        .dv_de_o(dv_de_o)
    );

    always #10 clk = ~clk;

    function automatic logic [15:0] mem_word(logic [15:0] a);
        return {a[7:0], ~a[7:0]};
    endfunction

    // vram model, one cycle latency
    always @(posedge clk) begin
        pend_sel  <= vram_sel_o;
        pend_addr <= vram_addr_o;
    end

    always @(negedge clk) begin
        if (pend_sel) begin
            vram_data_i = mem_word(pend_addr);
        end
    end

    function automatic logic [7:0] expect_pixel(int line, int col);
        logic [15:0] base;
        logic [15:0] w;
        int          k;
        if (sh_blank) begin
            return sh_cb;
        end
        base = sh_start + 16'(line) * sh_ll;
        case (sh_bpp)
            2'b10: begin
                w = mem_word(base + 16'(col / 2));
                return (col % 2 == 0) ? w[15:8] : w[7:0];
            end
            2'b01: begin
                w = mem_word(base + 16'(col / 4));
                k = col % 4;
                return {sh_cb[7:4], w[15 - 4*k -: 4]};   // msb nibble first
            end
            default: begin
                w = mem_word(base + 16'(col / 8));
                k = col % 8;
                return {sh_cb[7:4], w[7 - k] ? w[15:12] : w[11:8]};
            end
        endcase
    endfunction

    task automatic report_fail();
        $display("sim failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic write_reg(logic [4:0] r, logic [15:0] d);
        vgen_reg_num_i  = r;
        vgen_reg_data_i = d;
        vgen_reg_wr_i   = 1'b1;
        @(negedge clk);
        vgen_reg_wr_i   = 1'b0;
        if (r == 5'd0) begin
            assert (intr_signal_o == d[3:0]) else begin
                $display("MISMATCH intr_signal_o: got %h expected %h", intr_signal_o, d[3:0]);
                report_fail();
            end
            @(negedge clk);
            assert (intr_signal_o[2:0] == 3'b000) else begin
                $display("MISMATCH intr_signal_o[2:0]: got %h expected %h",
                         intr_signal_o[2:0], 3'b000);
                report_fail();
            end
        end
        case (r)
            5'd5: begin
                sh_cb    = d[15:8];
                sh_blank = d[7];
                sh_bpp   = d[5:4];
            end
            5'd6: sh_start = d;
            5'd7: sh_ll = d;
            default: begin
            end
        endcase
    endtask

    task automatic read_reg(logic [4:0] r, logic [15:0] exp);
        logic [15:0] want;
        intr_status_i  = 4'($random(seed));
        vgen_reg_num_i = r;
        @(negedge clk);
        want = (r == 5'd0) ? {12'h000, intr_status_i} : exp;
        assert (vgen_reg_data_o == want) else begin
            $display("MISMATCH vgen_reg_data_o reg %h: got %h expected %h",
                     r, vgen_reg_data_o, want);
            report_fail();
        end
    endtask

    task automatic wait_vsync(logic lvl);
        int t;
        t = 0;
        while (vsync_o != lvl) begin
            @(negedge clk);
            t++;
            if (t > 500000) begin
                $display("timed out waiting for vsync_o to reach %0d", lvl);
                report_fail();
            end
        end
    endtask

    // one whole frame from the end of a vsync pulse to the end of the next
    task automatic check_frame();
        int         cyc;
        int         hs_run;
        int         last_fall;
        int         falls;
        int         vs_low;
        int         de_run;
        int         de_lines;
        int         col;
        int         intr_cnt;
        int         hits;
        logic       hs_prev;
        logic       de_prev;
        logic       vs_seen;
        logic [7:0] exp;
        cyc = 0;
        hs_run = 0;
        last_fall = -1;
        falls = 0;
        vs_low = 0;
        de_run = 0;
        de_lines = 0;
        col = 0;
        intr_cnt = 0;
        hits = 0;
        wait_vsync(1'b0);
        wait_vsync(1'b1);
        hs_prev = hsync_o;
        de_prev = 1'b0;
        vs_seen = 1'b0;
        while (!(vs_seen && vsync_o)) begin
            @(negedge clk);
            cyc++;
            if (cyc > 430000) begin
                $display("timed out waiting for the end of the frame");
                report_fail();
            end
            if (!vsync_o) begin
                vs_seen = 1'b1;
                vs_low++;
            end
            if (hs_prev && !hsync_o) begin
                if (last_fall >= 0) begin
                    assert (cyc - last_fall == 800) else begin
                        $display("MISMATCH line period: got %h expected %h",
                                 cyc - last_fall, 800);
                        report_fail();
                    end
                end
                last_fall = cyc;
                falls++;
            end
            if (!hsync_o) begin
                hs_run++;
            end else if (!hs_prev) begin
                assert (hs_run == 96) else begin
                    $display("MISMATCH hsync_o low cycles: got %h expected %h", hs_run, 96);
                    report_fail();
                end
                hs_run = 0;
            end
            if (dv_de_o) begin
                exp = expect_pixel(de_lines, col);
                assert (color_index_o == exp) else begin
                    $display("MISMATCH color_index_o line %0d col %0d: got %h expected %h",
                             de_lines, col, color_index_o, exp);
                    report_fail();
                end
                foreach (probes[i]) begin
                    if (probes[i][47:32] == 16'(de_lines) && probes[i][31:16] == 16'(col)) begin
                        assert (color_index_o == probes[i][7:0]) else begin
                            $display("MISMATCH color_index_o probe: got %h expected %h",
                                     color_index_o, probes[i][7:0]);
                            report_fail();
                        end
                        hits++;
                    end
                end
                col++;
                de_run++;
            end else if (de_prev) begin
                assert (de_run == 640) else begin
                    $display("MISMATCH dv_de_o high cycles: got %h expected %h", de_run, 640);
                    report_fail();
                end
                de_run = 0;
                col = 0;
                de_lines++;
            end
            if (intr_signal_o[3]) begin
                intr_cnt++;
                assert (de_lines * 640 + col == 307200 && !vs_seen) else begin
                    $display("vertical blank interrupt came outside the blanking interval");
                    report_fail();
                end
            end
            if (sh_blank) begin
                assert (!vram_sel_o) else begin
                    $display("vram_sel_o went high while the display was blanked");
                    report_fail();
                end
            end
            hs_prev = hsync_o;
            de_prev = dv_de_o;
        end
        assert (cyc == 420000 && falls == 525 && vs_low == 1600) else begin
            $display("MISMATCH frame: cycles %h lines %h vsync cycles %h", cyc, falls, vs_low);
            report_fail();
        end
        assert (de_lines == 480 && intr_cnt == 1 && hits == probes.size()) else begin
            $display("MISMATCH frame: de lines %h intr pulses %h probes hit %h",
                     de_lines, intr_cnt, hits);
            report_fail();
        end
        probes.delete();
    endtask

    initial begin
        clk             = 1'b0;
        reset_i         = 1'b1;
        vgen_reg_wr_i   = 1'b0;
        vgen_reg_num_i  = 5'd0;
        vgen_reg_data_i = 16'h0000;
        intr_status_i   = 4'h0;
        vram_data_i     = 16'h0000;
        seed            = 32'h4b62;
        sh_cb           = 8'h00;
        sh_blank        = 1'b0;
        sh_bpp          = 2'b00;
        sh_start        = 16'h0000;
        sh_ll           = 16'd80;
        for (int i = 0; i < 64; i++) begin
            golden[i] = 64'h0;
        end
        $readmemh("verification/video_golden.txt", golden);
        repeat (2) @(negedge clk);
        reset_i = 1'b0;
        for (int i = 0; i < 64 && golden[i][63:48] != 16'h0; i++) begin
            case (golden[i][63:48])
                16'h1: write_reg(golden[i][36:32], golden[i][31:16]);
                16'h2: read_reg(golden[i][36:32], golden[i][31:16]);
                16'h3: probes.push_back({golden[i][47:32], golden[i][31:16], golden[i][15:0]});
                16'h4: check_frame();
                default: begin
                    $display("unknown record %0d in the golden file", i);
                    report_fail();
                end
            endcase
        end
        $display("sim passed");
        $finish;
    end

endmodule

//--- rtl/video_gen.sv
// bitmap video generator top level
// 640x480 timing, config registers, playfield A fetch and scan-out
module video_gen (
    input  wire logic              clk,
    input  wire logic              reset_i,
    input  wire logic              vgen_reg_wr_i,
    input  wire vgen_pkg::regnum_t vgen_reg_num_i,
    input  wire vgen_pkg::word_t   vgen_reg_data_i,
    output vgen_pkg::word_t        vgen_reg_data_o,
    input  wire logic [3:0]        intr_status_i,
    output logic [3:0]             intr_signal_o,
    output logic                   vram_sel_o,
    output vgen_pkg::vaddr_t       vram_addr_o,
    input  wire vgen_pkg::word_t   vram_data_i,
    output vgen_pkg::color_t       color_index_o,
    output logic                   hsync_o,
    output logic                   vsync_o,
    output logic                   dv_de_o
);

    vgen_timing_if   tim();
    plane_cfg_if     cfg();

    logic            hsync;
    logic            vsync;
    logic            de;
    logic            words_ready;
    logic            buf_empty;
    vgen_pkg::word_t word0;
    vgen_pkg::word_t word1;
    vgen_pkg::word_t word2;
    vgen_pkg::word_t word3;

    video_timing u_timing (
        .clk(clk), .reset_i(reset_i), .tim(tim.source), .cfg(cfg.fetch),
        .hsync_o(hsync), .vsync_o(vsync), .de_o(de)
    );

    video_regs u_regs (
        .clk(clk), .reset_i(reset_i),
        .reg_wr_i(vgen_reg_wr_i), .reg_num_i(vgen_reg_num_i),
        .reg_data_i(vgen_reg_data_i), .reg_data_o(vgen_reg_data_o),
        .intr_status_i(intr_status_i), .intr_signal_o(intr_signal_o),
        .tim(tim.regs), .cfg(cfg.source)
    );

    plane_fetch u_fetch (
        .clk(clk), .reset_i(reset_i), .tim(tim.fetch), .cfg(cfg.fetch),
        .vram_sel_o(vram_sel_o), .vram_addr_o(vram_addr_o), .vram_data_i(vram_data_i),
        .buf_empty_i(buf_empty), .words_ready_o(words_ready),
        .word0_o(word0), .word1_o(word1), .word2_o(word2), .word3_o(word3)
    );

    pixel_scanout u_scanout (
        .clk(clk), .reset_i(reset_i), .tim(tim.scan), .cfg(cfg.scan),
        .words_ready_i(words_ready),
        .word0_i(word0), .word1_i(word1), .word2_i(word2), .word3_i(word3),
        .buf_empty_o(buf_empty), .color_index_o(color_index_o)
    );

    // one register stage to line up with the registered pixel
    always_ff @(posedge clk) begin
        if (reset_i) begin
            hsync_o <= !vgen_pkg::H_SYNC_POLARITY;
            vsync_o <= !vgen_pkg::V_SYNC_POLARITY;
            dv_de_o <= 1'b0;
        end else begin
            hsync_o <= hsync ? vgen_pkg::H_SYNC_POLARITY : !vgen_pkg::H_SYNC_POLARITY;
            vsync_o <= vsync ? vgen_pkg::V_SYNC_POLARITY : !vgen_pkg::V_SYNC_POLARITY;
            dv_de_o <= de;
        end
    end

endmodule

//--- rtl/pixel_scanout.sv
// pixel expansion and scan-out
// expands fetched words into eight 8-bit indices and shifts them out
module pixel_scanout (
    input  wire logic             clk,
    input  wire logic             reset_i,
    vgen_timing_if.scan           tim,
    plane_cfg_if.scan             cfg,
    input  wire logic             words_ready_i,
    input  wire vgen_pkg::word_t  word0_i,
    input  wire vgen_pkg::word_t  word1_i,
    input  wire vgen_pkg::word_t  word2_i,
    input  wire vgen_pkg::word_t  word3_i,
    output logic                  buf_empty_o,
    output vgen_pkg::color_t      color_index_o
);

    logic [63:0]      expanded;         // next 8 pixels from word inputs
    logic [63:0]      pix_buf;          // waiting for scan-out
    logic [63:0]      pix_shift;        // msb byte is the current pixel
    logic [31:0]      nib_words;
    logic [63:0]      byte_words;
    logic             scanning;
    vgen_pkg::count_t col;              // visible column being shown

    assign nib_words  = {word0_i, word1_i};
    assign byte_words = {word0_i, word1_i, word2_i, word3_i};

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            case (cfg.bpp)
                vgen_pkg::BPP_1_ATTR:
                    expanded[63 - 8*i -: 8] = {cfg.colorbase[7:4], word0_i[7 - i] ?
                                               word0_i[vgen_pkg::ATTR_FORE +: 4] :
                                               word0_i[vgen_pkg::ATTR_BACK +: 4]};
                vgen_pkg::BPP_4:
                    expanded[63 - 8*i -: 8] = {cfg.colorbase[7:4], nib_words[31 - 4*i -: 4]};
                default:
                    expanded[63 - 8*i -: 8] = byte_words[63 - 8*i -: 8];
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            scanning      <= 1'b0;
            buf_empty_o   <= 1'b1;
            color_index_o <= '0;
        end else begin
            if (tim.line_start) begin
                buf_empty_o <= 1'b1;
            end
            if (scanning) begin
                col       <= col + 11'd1;
                pix_shift <= {pix_shift[55:0], 8'h00};
                if (col[2:0] == 3'd7) begin             // next group of 8
                    pix_shift   <= pix_buf;
                    buf_empty_o <= 1'b1;
                end
                if (col == vgen_pkg::count_t'(vgen_pkg::VISIBLE_WIDTH - 1)) begin
                    scanning <= 1'b0;
                end
            end
            if (tim.scanout_start) begin
                scanning    <= 1'b1;
                col         <= '0;
                pix_shift   <= pix_buf;
                buf_empty_o <= 1'b1;
            end
            if (words_ready_i) begin
                pix_buf     <= expanded;
                buf_empty_o <= 1'b0;
            end
            color_index_o <= (scanning && !cfg.blank) ? pix_shift[63:56] : cfg.colorbase;
        end
    end

endmodule

//--- rtl/plane_fetch.sv
// playfield A bitmap fetch
// reads 1, 2 or 4 display words per 8 pixels from VRAM into word buffers
module plane_fetch (
    input  wire logic             clk,
    input  wire logic             reset_i,
    vgen_timing_if.fetch          tim,
    plane_cfg_if.fetch            cfg,
    output logic                  vram_sel_o,
    output vgen_pkg::vaddr_t      vram_addr_o,
    input  wire vgen_pkg::word_t  vram_data_i,
    input  wire logic             buf_empty_i,
    output logic                  words_ready_o,
    output vgen_pkg::word_t       word0_o,
    output vgen_pkg::word_t       word1_o,
    output vgen_pkg::word_t       word2_o,
    output vgen_pkg::word_t       word3_o
);

    typedef enum logic [2:0] {
        FETCH_IDLE   = 3'd0,            // wait for line start
        FETCH_ADDR   = 3'd1,            // first address out when buffer has room
        FETCH_WAIT   = 3'd2,            // vram latency
        FETCH_READ_0 = 3'd3,
        FETCH_READ_1 = 3'd4,
        FETCH_READ_2 = 3'd5,
        FETCH_READ_3 = 3'd6
    } fetch_st_t;

    fetch_st_t        state;
    vgen_pkg::vaddr_t addr;             // next display word
    vgen_pkg::vaddr_t line_start;       // first word of current line
    logic             one_word;
    logic             four_words;
    logic             issue;            // put addr on vram this cycle

    assign one_word   = (cfg.bpp == vgen_pkg::BPP_1_ATTR);
    assign four_words = !one_word && (cfg.bpp != vgen_pkg::BPP_4);

    // addresses go out back to back, one per state
    always_comb begin
        case (state)
            FETCH_ADDR:   issue = tim.fetch_active && buf_empty_i && !words_ready_o;
            FETCH_WAIT:   issue = !one_word;
            FETCH_READ_0: issue = four_words;
            FETCH_READ_1: issue = four_words;
            default:      issue = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state         <= FETCH_IDLE;
            vram_sel_o    <= 1'b0;
            words_ready_o <= 1'b0;
        end else begin
            vram_sel_o    <= issue;
            words_ready_o <= 1'b0;
            if (issue) begin
                vram_addr_o <= addr;
                addr        <= addr + 16'd1;
            end
            case (state)
                FETCH_IDLE: begin
                    if (tim.line_start) begin
                        state <= FETCH_ADDR;
                    end
                end
                FETCH_ADDR: begin
                    if (!tim.fetch_active) begin
                        state <= FETCH_IDLE;
                    end else if (issue) begin
                        state <= FETCH_WAIT;
                    end
                end
                FETCH_WAIT: state <= FETCH_READ_0;
                FETCH_READ_0: begin
                    word0_o <= vram_data_i;             // pixels, or attr + pixels at 1 bpp
                    if (one_word) begin
                        words_ready_o <= 1'b1;
                        state         <= FETCH_ADDR;
                    end else begin
                        state <= FETCH_READ_1;
                    end
                end
                FETCH_READ_1: begin
                    word1_o <= vram_data_i;
                    if (four_words) begin
                        state <= FETCH_READ_2;
                    end else begin
                        words_ready_o <= 1'b1;
                        state         <= FETCH_ADDR;
                    end
                end
                FETCH_READ_2: begin
                    word2_o <= vram_data_i;
                    state   <= FETCH_READ_3;
                end
                FETCH_READ_3: begin
                    word3_o       <= vram_data_i;
                    words_ready_o <= 1'b1;
                    state         <= FETCH_ADDR;
                end
                default: state <= FETCH_IDLE;
            endcase

            if (tim.line_end) begin
                addr       <= line_start + cfg.line_len;   // step to next line
                line_start <= line_start + cfg.line_len;
            end
            if (tim.frame_end || cfg.blank) begin
                addr       <= cfg.start_addr;
                line_start <= cfg.start_addr;
            end
        end
    end

endmodule

//--- rtl/video_regs.sv
// video configuration registers
// register writes, read-back mux and interrupt pulses
module video_regs (
    input  wire logic              clk,
    input  wire logic              reset_i,
    input  wire logic              reg_wr_i,
    input  wire vgen_pkg::regnum_t reg_num_i,
    input  wire vgen_pkg::word_t   reg_data_i,
    output vgen_pkg::word_t        reg_data_o,
    input  wire logic [3:0]        intr_status_i,
    output logic [3:0]             intr_signal_o,
    vgen_timing_if.regs            tim,
    plane_cfg_if.source            cfg
);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            intr_signal_o  <= 4'b0000;
            cfg.colorbase  <= vgen_pkg::PA_COLORBASE_RESET;
            cfg.blank      <= 1'b0;
            cfg.bpp        <= vgen_pkg::PA_BPP_RESET;
            cfg.start_addr <= vgen_pkg::PA_START_RESET;
            cfg.line_len   <= vgen_pkg::PA_LINE_LEN_RESET;
        end else begin
            intr_signal_o <= {tim.last_visible, 3'b000};      // bit 3 is vertical blank
            if (reg_wr_i) begin
                case (reg_num_i)
                    vgen_pkg::XR_VID_CTRL: begin
                        intr_signal_o <= reg_data_i[3:0] | {tim.last_visible, 3'b000};
                    end
                    vgen_pkg::XR_PA_GFX_CTRL: begin
                        cfg.colorbase <= reg_data_i[15:8];
                        cfg.blank     <= reg_data_i[7];
                        cfg.bpp       <= vgen_pkg::bpp_t'(reg_data_i[5:4]);
                    end
                    vgen_pkg::XR_PA_DISP_ADDR: cfg.start_addr <= reg_data_i;
                    vgen_pkg::XR_PA_LINE_LEN:  cfg.line_len   <= reg_data_i;
                    default: begin
                    end
                endcase
            end
        end
    end

    // read-back, one cycle after the register number
    always_ff @(posedge clk) begin
        case (reg_num_i)
            vgen_pkg::XR_VID_CTRL:     reg_data_o <= {12'h000, intr_status_i};
            vgen_pkg::XR_SCANLINE:     reg_data_o <= {!tim.v_visible, !tim.h_visible, 3'b000,
                                                      tim.v_count};
            vgen_pkg::XR_VID_HSIZE:    reg_data_o <= vgen_pkg::word_t'(vgen_pkg::VISIBLE_WIDTH);
            vgen_pkg::XR_VID_VSIZE:    reg_data_o <= vgen_pkg::word_t'(vgen_pkg::VISIBLE_HEIGHT);
            vgen_pkg::XR_VID_VFREQ:    reg_data_o <= vgen_pkg::word_t'(vgen_pkg::REFRESH_FREQ);
            vgen_pkg::XR_PA_GFX_CTRL:  reg_data_o <= {cfg.colorbase, cfg.blank, 1'b0, cfg.bpp,
                                                      4'h0};
            vgen_pkg::XR_PA_DISP_ADDR: reg_data_o <= cfg.start_addr;
            vgen_pkg::XR_PA_LINE_LEN:  reg_data_o <= cfg.line_len;
            default:                   reg_data_o <= 16'h0000;
        endcase
    end

endmodule

//--- rtl/video_timing.sv
// video timing generator
// horizontal and vertical sync state machines, beam counters,
// fetch window and per-line / per-frame strobes
module video_timing (
    input  wire logic     clk,
    input  wire logic     reset_i,
    vgen_timing_if.source tim,
    plane_cfg_if.fetch    cfg,
    output logic          hsync_o,
    output logic          vsync_o,
    output logic          de_o
);

    vgen_pkg::video_st_t h_state;
    vgen_pkg::video_st_t v_state;
    vgen_pkg::count_t    h_end;         // last count of current h state
    vgen_pkg::count_t    v_end;
    logic                h_step;
    logic                v_step;
    logic                fetch_next;

    always_comb begin
        case (h_state)
            vgen_pkg::STATE_PRE_SYNC:  h_end = vgen_pkg::count_t'(vgen_pkg::H_FRONT_PORCH - 1);
            vgen_pkg::STATE_SYNC:      h_end = vgen_pkg::count_t'(vgen_pkg::H_FRONT_PORCH
                                                             + vgen_pkg::H_SYNC_PULSE - 1);
            vgen_pkg::STATE_POST_SYNC: h_end = vgen_pkg::count_t'(vgen_pkg::OFFSCREEN_WIDTH - 1);
            default:                   h_end = vgen_pkg::count_t'(vgen_pkg::TOTAL_WIDTH - 1);
        endcase
        // visible lines come first, blanking lines at the bottom
        case (v_state)
            vgen_pkg::STATE_PRE_SYNC:  v_end = vgen_pkg::count_t'(vgen_pkg::VISIBLE_HEIGHT
                                                             + vgen_pkg::V_FRONT_PORCH - 1);
            vgen_pkg::STATE_SYNC:      v_end = vgen_pkg::count_t'(vgen_pkg::VISIBLE_HEIGHT
                                           + vgen_pkg::V_FRONT_PORCH + vgen_pkg::V_SYNC_PULSE - 1);
            vgen_pkg::STATE_POST_SYNC: v_end = vgen_pkg::count_t'(vgen_pkg::TOTAL_HEIGHT - 1);
            default:                   v_end = vgen_pkg::count_t'(vgen_pkg::VISIBLE_HEIGHT - 1);
        endcase
    end

    assign h_step            = (tim.h_count == h_end);
    assign tim.line_end      = h_step && (h_state == vgen_pkg::STATE_VISIBLE);
    assign v_step            = tim.line_end && (tim.v_count == v_end);
    assign tim.last_visible  = v_step && (v_state == vgen_pkg::STATE_VISIBLE);
    assign tim.frame_end     = v_step && (v_state == vgen_pkg::STATE_POST_SYNC);
    assign tim.h_visible     = (h_state == vgen_pkg::STATE_VISIBLE);
    assign tim.v_visible     = (v_state == vgen_pkg::STATE_VISIBLE);

    // fetch window toggles at H_MEM_BEGIN and H_MEM_END on visible lines
    assign fetch_next = (tim.v_visible && tim.h_count == (tim.fetch_active ?
                         vgen_pkg::H_MEM_END : vgen_pkg::H_MEM_BEGIN)) ?
                        !tim.fetch_active : tim.fetch_active;
    assign tim.line_start    = !tim.fetch_active && fetch_next && !cfg.blank;
    assign tim.scanout_start = tim.fetch_active && (tim.h_count == vgen_pkg::H_SCANOUT_BEGIN);

    assign hsync_o = (h_state == vgen_pkg::STATE_SYNC);
    assign vsync_o = (v_state == vgen_pkg::STATE_SYNC);
    assign de_o    = tim.h_visible && tim.v_visible;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_state          <= vgen_pkg::STATE_PRE_SYNC;
            v_state          <= vgen_pkg::STATE_POST_SYNC;    // last blank line, frame follows
            tim.h_count      <= '0;
            tim.v_count      <= vgen_pkg::count_t'(vgen_pkg::TOTAL_HEIGHT - 1);
            tim.fetch_active <= 1'b0;
        end else begin
            if (h_step) begin
                h_state <= vgen_pkg::video_st_t'(h_state + 2'd1);
            end
            if (v_step) begin
                v_state <= vgen_pkg::video_st_t'(v_state + 2'd1);
            end
            tim.h_count <= tim.line_end ? '0 : tim.h_count + 11'd1;
            if (tim.line_end) begin
                tim.v_count <= tim.frame_end ? '0 : tim.v_count + 11'd1;
            end
            tim.fetch_active <= fetch_next && !cfg.blank;      // blank holds fetch off
        end
    end

endmodule

//--- rtl/plane_cfg_if.sv
// playfield A configuration from the register file
interface plane_cfg_if;
    vgen_pkg::color_t colorbase;
    logic             blank;
    vgen_pkg::bpp_t   bpp;
    vgen_pkg::vaddr_t start_addr;
    vgen_pkg::vaddr_t line_len;         // words per display line

    modport source (output colorbase, blank, bpp, start_addr, line_len);
    modport fetch  (input blank, bpp, start_addr, line_len);
    modport scan   (input colorbase, blank, bpp);
endinterface

//--- rtl/vgen_timing_if.sv
// beam position and timing strobes from the sync generator
interface vgen_timing_if;
    vgen_pkg::count_t h_count;
    vgen_pkg::count_t v_count;
    logic             h_visible;
    logic             v_visible;
    logic             fetch_active;     // inside fetch window, not blanked
    logic             line_start;
    logic             scanout_start;
    logic             line_end;
    logic             frame_end;
    logic             last_visible;

    modport source (output h_count, v_count, h_visible, v_visible, fetch_active,
                    line_start, scanout_start, line_end, frame_end, last_visible);
    modport fetch  (input fetch_active, line_start, line_end, frame_end);
    modport scan   (input scanout_start, line_start);
    modport regs   (input v_count, h_visible, v_visible, last_visible);
endinterface

//--- rtl/vgen_pkg.sv
// video generator shared definitions
// 640x480 mode timing, register map and common types
package vgen_pkg;

    typedef logic [10:0] count_t;       // beam counter
    typedef logic [15:0] vaddr_t;       // vram word address
    typedef logic [15:0] word_t;        // register or memory word
    typedef logic [7:0]  color_t;       // palette index
    typedef logic [4:0]  regnum_t;      // config register number

    typedef enum logic [1:0] {
        BPP_1_ATTR = 2'b00,             // 1 bpp with fore/back attribute byte
        BPP_4      = 2'b01,
        BPP_8      = 2'b10
    } bpp_t;

    typedef enum logic [1:0] {
        STATE_PRE_SYNC  = 2'b00,
        STATE_SYNC      = 2'b01,
        STATE_POST_SYNC = 2'b10,
        STATE_VISIBLE   = 2'b11
    } video_st_t;

    // 640x480 at 60 Hz with a 25 MHz pixel clock
    localparam int VISIBLE_WIDTH   = 640;
    localparam int VISIBLE_HEIGHT  = 480;
    localparam int H_FRONT_PORCH   = 16;
    localparam int H_SYNC_PULSE    = 96;
    localparam int H_BACK_PORCH    = 48;
    localparam int V_FRONT_PORCH   = 10;
    localparam int V_SYNC_PULSE    = 2;
    localparam int V_BACK_PORCH    = 33;
    localparam int OFFSCREEN_WIDTH = H_FRONT_PORCH + H_SYNC_PULSE + H_BACK_PORCH;
    localparam int TOTAL_WIDTH     = VISIBLE_WIDTH + OFFSCREEN_WIDTH;
    localparam int TOTAL_HEIGHT    = VISIBLE_HEIGHT + V_FRONT_PORCH + V_SYNC_PULSE + V_BACK_PORCH;
    localparam logic H_SYNC_POLARITY = 1'b0;
    localparam logic V_SYNC_POLARITY = 1'b0;
    localparam int REFRESH_FREQ    = 60;

    localparam count_t H_MEM_BEGIN     = count_t'(OFFSCREEN_WIDTH - 64);  // prefetch starts early
    localparam count_t H_MEM_END       = count_t'(TOTAL_WIDTH - 8);
    localparam count_t H_SCANOUT_BEGIN = count_t'(OFFSCREEN_WIDTH - 1);   // one before first pixel

    localparam regnum_t XR_VID_CTRL     = 5'd0;
    localparam regnum_t XR_SCANLINE     = 5'd1;
    localparam regnum_t XR_VID_HSIZE    = 5'd2;
    localparam regnum_t XR_VID_VSIZE    = 5'd3;
    localparam regnum_t XR_VID_VFREQ    = 5'd4;
    localparam regnum_t XR_PA_GFX_CTRL  = 5'd5;
    localparam regnum_t XR_PA_DISP_ADDR = 5'd6;
    localparam regnum_t XR_PA_LINE_LEN  = 5'd7;

    localparam int ATTR_FORE = 12;      // attribute nibbles, lsb positions
    localparam int ATTR_BACK = 8;

    localparam color_t PA_COLORBASE_RESET = 8'h00;
    localparam bpp_t   PA_BPP_RESET       = BPP_1_ATTR;
    localparam vaddr_t PA_START_RESET     = 16'h0000;
    localparam vaddr_t PA_LINE_LEN_RESET  = 16'd80;

endpackage
